/* kvs_pkg.sv */
////////////////////
// Stream word widths, lane count and the raw/lanes word union
////////////////////
package kvs_pkg;

  // Stream word and adder lane widths
  localparam int DATA_WIDTH = 128;
  localparam int LANE_WIDTH = 32;
  localparam int NUM_LANES  = DATA_WIDTH / LANE_WIDTH;

  // Transfer length in words
  localparam int XFER_WIDTH = 32;

  // One stream word, seen whole or as adder lanes (lane 0 in the low bits)
  typedef union packed {
    logic [DATA_WIDTH-1:0]                raw;
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] lanes;
  } data_word_u;

endpackage : kvs_pkg

/* stream_rx.sv */
////////////////////
// Input word FIFO with credit return on every pop
////////////////////
`timescale 1ns/1ps
`default_nettype none

module stream_rx import kvs_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       ap_clk,
  input  logic       areset,
  input  logic       in_valid,
  input  data_word_u in_data,
  output logic       in_credit,
  output logic       rd_valid,
  output data_word_u rd_data,
  input  logic       rd_ready
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  full;
  logic                  push;
  logic                  pop;

  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign push     = in_valid && !full;
  assign pop      = rd_valid && rd_ready;
  assign rd_valid = (count != '0);
  assign rd_data.raw = mem[rd_ptr];

  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data.raw;
    end
  end

  ////////////////////
  // Pointers and fill level
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // One credit back upstream per freed slot
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      in_credit <= 1'b0;
    end else begin
      in_credit <= pop;
    end
  end

  a_no_push_when_full: assert property (@(posedge ap_clk) disable iff (areset)
    in_valid |-> !full)
    else $error("Upstream sent a word without a credit");

endmodule : stream_rx

`default_nettype wire

/* lane_adder.sv */
////////////////////
// Two-stage stallable pipeline adding a constant to each lane
////////////////////
`timescale 1ns/1ps
`default_nettype none

module lane_adder import kvs_pkg::*; #(
  parameter logic [LANE_WIDTH-1:0] ADD_CONSTANT = 1
) (
  input  logic       ap_clk,
  input  logic       areset,
  input  logic       rd_valid,
  input  data_word_u rd_data,
  output logic       rd_ready,
  output logic       wr_valid,
  output data_word_u wr_data,
  input  logic       wr_ready
);

  logic       s1_valid;
  logic       s2_valid;
  logic       s1_ready;
  logic       s2_ready;
  data_word_u s1_data;
  data_word_u s2_data;

  // A stage moves when the next one is empty or emptying
  assign s2_ready = !s2_valid || wr_ready;
  assign s1_ready = !s1_valid || s2_ready;

  assign rd_ready = s1_ready;
  assign wr_valid = s2_valid;
  assign wr_data  = s2_data;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= rd_valid;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  ////////////////////
  // Data path, wraps per lane
  always_ff @(posedge ap_clk) begin
    if (s1_ready && rd_valid) begin
      s1_data <= rd_data;
    end
    if (s2_ready && s1_valid) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        s2_data.lanes[i] <= s1_data.lanes[i] + ADD_CONSTANT;
      end
    end
  end

endmodule : lane_adder

`default_nettype wire

/* stream_tx.sv */
////////////////////
// Output credit counter, run word counter and channel done
////////////////////
`timescale 1ns/1ps
`default_nettype none

module stream_tx import kvs_pkg::*; #(
  parameter int CREDIT_MAX = 4
) (
  input  logic                  ap_clk,
  input  logic                  areset,
  input  logic                  start_pulse,
  input  logic [XFER_WIDTH-1:0] xfer_words,
  input  logic                  wr_valid,
  input  data_word_u            wr_data,
  output logic                  wr_ready,
  output logic                  out_valid,
  output data_word_u            out_data,
  input  logic                  out_credit,
  output logic                  chan_done
);

  localparam int CRED_W = $clog2(CREDIT_MAX + 1);

  logic [CRED_W-1:0]     credit_q;
  logic                  send;
  logic                  active_q;
  logic [XFER_WIDTH-1:0] sent_q;

  assign wr_ready     = (credit_q != '0);
  assign send         = wr_valid && wr_ready;
  assign out_valid    = send;
  assign out_data.raw = wr_data.raw;

  ////////////////////
  // Credits from downstream
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      credit_q <= CRED_W'(CREDIT_MAX);
    end else if (send && !out_credit) begin
      credit_q <= credit_q - 1'b1;
    end else if (out_credit && !send) begin
      credit_q <= credit_q + 1'b1;
    end
  end

  ////////////////////
  // Words sent in the current run
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      active_q <= 1'b0;
      sent_q   <= '0;
    end else if (start_pulse) begin
      active_q <= 1'b1;
      sent_q   <= XFER_WIDTH'(send);
    end else if (chan_done) begin
      active_q <= 1'b0;
    end else if (active_q && send) begin
      sent_q <= sent_q + 1'b1;
    end
  end

  // Zero-length run finishes right after start
  assign chan_done = active_q && (sent_q == xfer_words);

  a_credit_max: assert property (@(posedge ap_clk) disable iff (areset)
    (out_credit && !send) |-> (credit_q < CRED_W'(CREDIT_MAX)))
    else $error("Output credit count above CREDIT_MAX");

endmodule : stream_tx

`default_nettype wire

/* kernel_ctrl.sv */
////////////////////
// Kernel start/idle/done control and transfer length latch
////////////////////
`timescale 1ns/1ps
`default_nettype none

module kernel_ctrl import kvs_pkg::*; #(
  parameter int NUM_CHANNELS = 2
) (
  input  logic                    ap_clk,
  input  logic                    areset,
  input  logic                    ap_start,
  input  logic [XFER_WIDTH-1:0]   data_num,
  input  logic [NUM_CHANNELS-1:0] chan_done,
  output logic                    start_pulse,
  output logic [XFER_WIDTH-1:0]   xfer_words,
  output logic                    ap_idle,
  output logic                    ap_done
);

  logic                    ap_start_q;
  logic                    ap_idle_q;
  logic [NUM_CHANNELS-1:0] done_flags_q;

  // Rising edge of ap_start
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_start_q <= 1'b0;
    end else begin
      ap_start_q <= ap_start;
    end
  end

  assign start_pulse = ap_start && !ap_start_q;

  // Length is held for the whole run
  always_ff @(posedge ap_clk) begin
    if (start_pulse) begin
      xfer_words <= data_num;
    end
  end

  ////////////////////
  // Idle and done
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_idle_q <= 1'b1;
    end else if (ap_done) begin
      ap_idle_q <= 1'b1;
    end else if (start_pulse) begin
      ap_idle_q <= 1'b0;
    end
  end

  assign ap_idle = ap_idle_q;

  // Sticky per-channel flags, cleared once all are in
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      done_flags_q <= '0;
    end else if (start_pulse || ap_done) begin
      done_flags_q <= '0;
    end else begin
      done_flags_q <= done_flags_q | chan_done;
    end
  end

  assign ap_done = &done_flags_q;

  a_no_done_on_start: assert property (@(posedge ap_clk) disable iff (areset)
    !ap_idle |-> !(ap_done && start_pulse))
    else $error("ap_done and start_pulse together during a run");

endmodule : kernel_ctrl

`default_nettype wire

/* vadd_channel.sv */
////////////////////
// One channel: input FIFO, lane adder and output stage
////////////////////
`timescale 1ns/1ps
`default_nettype none

module vadd_channel import kvs_pkg::*; #(
  parameter int                    FIFO_DEPTH   = 4,
  parameter int                    CREDIT_MAX   = 4,
  parameter logic [LANE_WIDTH-1:0] ADD_CONSTANT = 1
) (
  input  logic                  ap_clk,
  input  logic                  areset,
  input  logic                  start_pulse,
  input  logic [XFER_WIDTH-1:0] xfer_words,
  input  logic                  in_valid,
  input  data_word_u            in_data,
  output logic                  in_credit,
  output logic                  out_valid,
  output data_word_u            out_data,
  input  logic                  out_credit,
  output logic                  chan_done
);

  logic       rd_valid;
  logic       rd_ready;
  data_word_u rd_data;
  logic       wr_valid;
  logic       wr_ready;
  data_word_u wr_data;

  stream_rx #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) stream_rx_i (
    .ap_clk    (ap_clk),
    .areset    (areset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_credit (in_credit),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .rd_ready  (rd_ready)
  );

  lane_adder #(
    .ADD_CONSTANT (ADD_CONSTANT)
  ) lane_adder_i (
    .ap_clk   (ap_clk),
    .areset   (areset),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .rd_ready (rd_ready),
    .wr_valid (wr_valid),
    .wr_data  (wr_data),
    .wr_ready (wr_ready)
  );

  stream_tx #(
    .CREDIT_MAX (CREDIT_MAX)
  ) stream_tx_i (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .start_pulse (start_pulse),
    .xfer_words  (xfer_words),
    .wr_valid    (wr_valid),
    .wr_data     (wr_data),
    .wr_ready    (wr_ready),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_credit  (out_credit),
    .chan_done   (chan_done)
  );

endmodule : vadd_channel

`default_nettype wire

/* kvs_kernel_top.sv */
////////////////////
// Stream kernel top: control block and parallel channels
////////////////////
`timescale 1ns/1ps
`default_nettype none

module kvs_kernel_top import kvs_pkg::*; #(
  parameter int                    NUM_CHANNELS = 2,
  parameter int                    FIFO_DEPTH   = 4,
  parameter int                    CREDIT_MAX   = 4,
  parameter logic [LANE_WIDTH-1:0] ADD_CONSTANT = 1
) (
  input  logic                                ap_clk,
  input  logic                                areset,
  input  logic                                ap_start,
  output logic                                ap_idle,
  output logic                                ap_done,
  input  logic [XFER_WIDTH-1:0]               data_num,
  input  logic [NUM_CHANNELS-1:0]             in_valid,
  input  data_word_u [NUM_CHANNELS-1:0]       in_data,
  output logic [NUM_CHANNELS-1:0]             in_credit,
  output logic [NUM_CHANNELS-1:0]             out_valid,
  output data_word_u [NUM_CHANNELS-1:0]       out_data,
  input  logic [NUM_CHANNELS-1:0]             out_credit
);

  logic                    start_pulse;
  logic [XFER_WIDTH-1:0]   xfer_words;
  logic [NUM_CHANNELS-1:0] chan_done;

  kernel_ctrl #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) kernel_ctrl_i (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .ap_start    (ap_start),
    .data_num    (data_num),
    .chan_done   (chan_done),
    .start_pulse (start_pulse),
    .xfer_words  (xfer_words),
    .ap_idle     (ap_idle),
    .ap_done     (ap_done)
  );

  ////////////////////
  // Channels
  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
    vadd_channel #(
      .FIFO_DEPTH   (FIFO_DEPTH),
      .CREDIT_MAX   (CREDIT_MAX),
      .ADD_CONSTANT (ADD_CONSTANT)
    ) vadd_channel_i (
      .ap_clk      (ap_clk),
      .areset      (areset),
      .start_pulse (start_pulse),
      .xfer_words  (xfer_words),
      .in_valid    (in_valid[ch]),
      .in_data     (in_data[ch]),
      .in_credit   (in_credit[ch]),
      .out_valid   (out_valid[ch]),
      .out_data    (out_data[ch]),
      .out_credit  (out_credit[ch]),
      .chan_done   (chan_done[ch])
    );
  end

endmodule : kvs_kernel_top

`default_nettype wire

/* tb_kvs_kernel.sv */
////////////////////
// Table-driven testbench for the stream kernel
// Credit models on both stream sides, per-channel expected word rings
////////////////////
`timescale 1ns/1ps

module tb_kvs_kernel import kvs_pkg::*; ();

  localparam int                    NUM_CH       = 2;
  localparam int                    FIFO_DEPTH   = 4;
  localparam int                    CREDIT_MAX   = 4;
  localparam logic [LANE_WIDTH-1:0] ADD_CONSTANT = 1;
  localparam int                    RING         = 64;
  localparam int                    RUN_TIMEOUT  = 2000;
  localparam int                    IDLE_TIMEOUT = 10;
  localparam int                    N_ROWS       = 6;

  // Columns: data_num, out_credit return delay in cycles, ap_start held for the run
  int tbl_num   [N_ROWS] = '{5, 8, 0, 12, 7, 10};
  int tbl_delay [N_ROWS] = '{0, 3, 0, 30, 1, 6};
  bit tbl_hold  [N_ROWS] = '{0, 0, 0, 1, 1, 0};

  logic                    ap_clk;
  logic                    areset;
  logic                    ap_start;
  logic                    ap_idle;
  logic                    ap_done;
  logic [XFER_WIDTH-1:0]   data_num;
  logic [NUM_CH-1:0]       in_valid;
  data_word_u [NUM_CH-1:0] in_data;
  logic [NUM_CH-1:0]       in_credit;
  logic [NUM_CH-1:0]       out_valid;
  data_word_u [NUM_CH-1:0] out_data;
  logic [NUM_CH-1:0]       out_credit;

  logic [DATA_WIDTH-1:0] exp_mem [NUM_CH][RING];
  int exp_wr [NUM_CH];
  int exp_rd [NUM_CH];
  int ret_time [NUM_CH][RING];
  int ret_wr [NUM_CH];
  int ret_rd [NUM_CH];
  int in_cred [NUM_CH];
  int outstanding [NUM_CH];
  int rx_count [NUM_CH];
  int icred_cnt [NUM_CH];
  int errors;
  int cyc;
  int run_words;
  int credit_delay;
  int done_cnt;
  bit idle_exp;
  bit start_prev;
  bit done_prev;
  bit timed_out;

  kvs_kernel_top #(
    .NUM_CHANNELS (NUM_CH),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .CREDIT_MAX   (CREDIT_MAX),
    .ADD_CONSTANT (ADD_CONSTANT)
  ) kvs_kernel_top_i (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .ap_start   (ap_start),
    .ap_idle    (ap_idle),
    .ap_done    (ap_done),
    .data_num   (data_num),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  task automatic log_mismatch(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  ////////////////////
  // Downstream: return one out_credit per word after the row's delay
  always @(posedge ap_clk) begin
    logic [NUM_CH-1:0] credit_next;
    cyc++;
    credit_next = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (!areset && ret_rd[ch] != ret_wr[ch] && ret_time[ch][ret_rd[ch] % RING] <= cyc) begin
        credit_next[ch] = 1'b1;
        ret_rd[ch]++;
      end
    end
    out_credit <= credit_next;
  end

  ////////////////////
  // Monitor, sampled mid-cycle
  always @(negedge ap_clk) begin
    if (areset) begin
      idle_exp   = 1'b1;
      start_prev = 1'b0;
      done_prev  = 1'b0;
    end else begin
      if (ap_idle !== idle_exp) begin
        log_mismatch($sformatf("ap_idle is %0b, expected %0b", ap_idle, idle_exp));
      end
      if (ap_done === 1'b1) begin
        done_cnt++;
        if (done_prev) begin
          log_mismatch("ap_done high for more than one cycle");
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
          if (rx_count[ch] != run_words) begin
            log_mismatch($sformatf("ap_done with ch%0d at %0d of %0d words",
                                   ch, rx_count[ch], run_words));
          end
        end
      end
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (in_credit[ch] === 1'b1) begin
          icred_cnt[ch]++;
          in_cred[ch]++;
          if (in_cred[ch] > FIFO_DEPTH) begin
            log_mismatch($sformatf("ch%0d returned more in_credit than FIFO_DEPTH", ch));
          end
        end
        if (out_valid[ch] === 1'b1) begin
          if (exp_rd[ch] == exp_wr[ch]) begin
            log_mismatch($sformatf("ch%0d sent a word that was never expected", ch));
          end else begin
            if (out_data[ch].raw !== exp_mem[ch][exp_rd[ch] % RING]) begin
              log_mismatch($sformatf("ch%0d out_data %h, expected %h", ch,
                                     out_data[ch].raw, exp_mem[ch][exp_rd[ch] % RING]));
            end
            exp_rd[ch]++;
          end
          rx_count[ch]++;
          outstanding[ch]++;
          if (outstanding[ch] > CREDIT_MAX) begin
            log_mismatch($sformatf("ch%0d has %0d words without credit back",
                                   ch, outstanding[ch]));
          end
          ret_time[ch][ret_wr[ch] % RING] = cyc + 1 + credit_delay;
          ret_wr[ch]++;
        end
        if (out_credit[ch]) begin
          outstanding[ch]--;
        end
      end
      // Idle falls after the start edge and rises after ap_done
      if (ap_done === 1'b1) begin
        idle_exp = 1'b1;
      end else if (ap_start && !start_prev) begin
        idle_exp = 1'b0;
      end
      start_prev = ap_start;
      done_prev  = (ap_done === 1'b1);
    end
  end

  ////////////////////
  // One table row: start, feed words under input credits, wait for done
  task automatic run_row(input int row, output bit to);
    int                      sent [NUM_CH];
    int                      cycles;
    logic [NUM_CH-1:0]       valid_next;
    data_word_u [NUM_CH-1:0] data_next;
    logic [DATA_WIDTH-1:0]   word;
    to = 1'b0;
    run_words    = tbl_num[row];
    credit_delay = tbl_delay[row];
    done_cnt     = 0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      sent[ch]      = 0;
      rx_count[ch]  = 0;
      icred_cnt[ch] = 0;
    end
    @(posedge ap_clk);
    ap_start <= 1'b1;
    data_num <= XFER_WIDTH'(tbl_num[row]);
    cycles = 0;
    while (done_cnt == 0 && !to) begin
      @(posedge ap_clk);
      if (!tbl_hold[row]) begin
        ap_start <= 1'b0;
      end
      valid_next = '0;
      data_next  = '0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (sent[ch] < run_words && in_cred[ch] > 0) begin
          for (int i = 0; i < NUM_LANES; i++) begin
            word[LANE_WIDTH*i +: LANE_WIDTH] = $urandom();
            exp_mem[ch][exp_wr[ch] % RING][LANE_WIDTH*i +: LANE_WIDTH] =
              word[LANE_WIDTH*i +: LANE_WIDTH] + ADD_CONSTANT;
          end
          exp_wr[ch]++;
          valid_next[ch]    = 1'b1;
          data_next[ch].raw = word;
          in_cred[ch]--;
          sent[ch]++;
        end
      end
      in_valid <= valid_next;
      in_data  <= data_next;
      cycles++;
      if (cycles > RUN_TIMEOUT) begin
        $display("Timeout: row %0d got no ap_done within %0d cycles", row, RUN_TIMEOUT);
        to = 1'b1;
      end
    end
    if (!to) begin
      cycles = 0;
      @(negedge ap_clk);
      while (ap_idle !== 1'b1 && cycles < IDLE_TIMEOUT) begin
        @(negedge ap_clk);
        cycles++;
      end
      if (ap_idle !== 1'b1) begin
        $display("Timeout: ap_idle did not come back after ap_done in row %0d", row);
        to = 1'b1;
      end
    end
    if (!to && tbl_hold[row]) begin
      // Held start must not launch a second run
      repeat (6) @(posedge ap_clk);
      ap_start <= 1'b0;
    end
    if (done_cnt != 1) begin
      log_mismatch($sformatf("row %0d saw %0d ap_done pulses", row, done_cnt));
    end
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (rx_count[ch] != run_words) begin
        log_mismatch($sformatf("row %0d ch%0d gave %0d words, expected %0d",
                               row, ch, rx_count[ch], run_words));
      end
      if (icred_cnt[ch] != sent[ch]) begin
        log_mismatch($sformatf("row %0d ch%0d gave %0d in_credit pulses for %0d words",
                               row, ch, icred_cnt[ch], sent[ch]));
      end
    end
  endtask

  initial begin
    void'($urandom(76850));
    errors     = 0;
    cyc        = 0;
    timed_out  = 1'b0;
    areset     = 1'b1;
    ap_start   = 1'b0;
    data_num   = '0;
    in_valid   = '0;
    in_data    = '0;
    out_credit = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      in_cred[ch]     = FIFO_DEPTH;
      outstanding[ch] = 0;
      exp_wr[ch]      = 0;
      exp_rd[ch]      = 0;
      ret_wr[ch]      = 0;
      ret_rd[ch]      = 0;
    end
    repeat (10) @(posedge ap_clk);
    areset <= 1'b0;
    @(negedge ap_clk);
    if (ap_idle !== 1'b1 || ap_done !== 1'b0 || out_valid !== '0 || in_credit !== '0) begin
      log_mismatch("outputs after reset are not idle=1, done=0, out_valid=0, in_credit=0");
    end
    for (int row = 0; row < N_ROWS && !timed_out; row++) begin
      run_row(row, timed_out);
    end
    if (timed_out) begin
      errors++;
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_kvs_kernel

/* kvs_kernel_top.f */
kvs_pkg.sv
stream_rx.sv
lane_adder.sv
stream_tx.sv
kernel_ctrl.sv
vadd_channel.sv
kvs_kernel_top.sv
tb_kvs_kernel.sv

/* Bender.yml */
package:
  name: kvs_kernel

sources:
  - kvs_pkg.sv
  - stream_rx.sv
  - lane_adder.sv
  - stream_tx.sv
  - kernel_ctrl.sv
  - vadd_channel.sv
  - kvs_kernel_top.sv
  - target: test
    files:
      - tb_kvs_kernel.sv
